/* hdl/fight_geom_pkg.sv */
package fight_geom_pkg;

  // screen coordinates for both axes.
  localparam int coord_w = 10;

  typedef logic [coord_w-1:0] coord_t;

  // reset positions of the two fighters.
  localparam coord_t start_x_left  = 10'd210;
  localparam coord_t start_x_right = 10'd420;
  localparam coord_t start_y       = 10'd140;

  // horizontal step per game cycle while moving.
  localparam coord_t move_speed = 10'd10;

  // legal x range; a fighter stepping outside it is put back at home.
  localparam coord_t arena_min  = 10'd50;
  localparam coord_t arena_max  = 10'd590;
  localparam coord_t arena_home = 10'd240;

  // attack hitbox offsets, the same on both sides.
  localparam coord_t hit_x_lo = 10'd37;
  localparam coord_t hit_x_hi = 10'd113;
  localparam coord_t hit_y_lo = 10'd24;
  localparam coord_t hit_y_hi = 10'd57;

  // body hurtbox x offsets differ per side.
  localparam coord_t hurt_x_lo_left  = 10'd37;
  localparam coord_t hurt_x_hi_left  = 10'd86;
  localparam coord_t hurt_x_lo_right = 10'd64;
  localparam coord_t hurt_x_hi_right = 10'd113;

  // hurtbox spans from the fighter's y down by this much.
  localparam coord_t hurt_y_hi = 10'd150;

endpackage

/* hdl/fight_state_pkg.sv */
package fight_state_pkg;

  // fighter FSM encoding.
  typedef enum logic [3:0] {
    idle          = 4'd0,
    move_forward  = 4'd1,
    move_backward = 4'd2,
    attack_start  = 4'd3,
    attack_end    = 4'd4,
    attack_pull   = 4'd5
  } fighter_state_t;

  // length of each attack phase in game steps.
  localparam int startup_len  = 5;
  localparam int active_len   = 2;
  localparam int recovery_len = 16;

  // health counter.
  localparam int health_w = 3;
  localparam logic [health_w-1:0] health_full = 3'd5;

endpackage

/* hdl/phase_counter.sv */
`timescale 1ns/1ps

module phase_counter #(
  parameter int w = 5
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         clear,
  output logic [w-1:0] count
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (count != '1) begin
      count <= count + 1'b1; // holds at all ones once reached.
    end
  end

endmodule

/* hdl/player.sv */
`timescale 1ns/1ps

module player #(
  parameter bit side = 1'b0
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           left,
  input  logic                           right,
  input  logic                           attack,
  output fight_state_pkg::fighter_state_t state,
  output fight_geom_pkg::coord_t         pos_x,
  output fight_geom_pkg::coord_t         pos_y,
  output fight_geom_pkg::coord_t         hit_x1,
  output fight_geom_pkg::coord_t         hit_x2,
  output fight_geom_pkg::coord_t         hit_y1,
  output fight_geom_pkg::coord_t         hit_y2,
  output fight_geom_pkg::coord_t         hurt_x1,
  output fight_geom_pkg::coord_t         hurt_x2,
  output fight_geom_pkg::coord_t         hurt_y1,
  output fight_geom_pkg::coord_t         hurt_y2
);
  import fight_geom_pkg::*;
  import fight_state_pkg::*;

  localparam int cnt_w = $clog2(recovery_len + 1);
  localparam logic [cnt_w-1:0] start_last = cnt_w'(startup_len - 1);
  localparam logic [cnt_w-1:0] active_last = cnt_w'(active_len - 1);
  localparam logic [cnt_w-1:0] pull_last = cnt_w'(recovery_len - 1);

  fighter_state_t   next_state;
  logic             clear;
  logic [cnt_w-1:0] count;
  logic             step_up;
  logic             step_down;
  coord_t           step_x;

  phase_counter #(.w(cnt_w)) u_phase (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .count (count)
  );

  always_comb begin
    next_state = state;
    clear = 1'b0;
    case (state)
      idle, move_forward, move_backward: begin
        if (attack) begin
          next_state = attack_start;
          clear = 1'b1;
        end else if (left && right) begin
          next_state = move_backward;
        end else if (left) begin
          next_state = side ? move_forward : move_backward; // left points at the left fighter.
        end else if (right) begin
          next_state = side ? move_backward : move_forward;
        end else begin
          next_state = idle;
        end
      end
      attack_start: begin
        if (count == start_last) begin
          next_state = attack_end;
          clear = 1'b1;
        end
      end
      attack_end: begin
        if (count == active_last) begin
          next_state = attack_pull;
          clear = 1'b1;
        end
      end
      attack_pull: begin
        if (count == pull_last) begin
          next_state = idle;
        end
      end
      default: next_state = idle;
    endcase
  end

  // left fighter walks forward toward higher x, right fighter toward lower x.
  assign step_up = (state == move_forward && !side) || (state == move_backward && side);
  assign step_down = (state == move_forward && side) || (state == move_backward && !side);
  assign step_x = step_up ? pos_x + move_speed : step_down ? pos_x - move_speed : pos_x;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= idle;
      pos_x <= side ? start_x_right : start_x_left;
      pos_y <= start_y;
    end else begin
      state <= next_state;
      pos_y <= pos_y;
      if (step_x < arena_min || step_x > arena_max) begin
        pos_x <= arena_home;
      end else begin
        pos_x <= step_x;
      end
    end
  end

  assign hit_x1 = pos_x + hit_x_lo;
  assign hit_x2 = pos_x + hit_x_hi;
  assign hit_y1 = pos_y + hit_y_lo;
  assign hit_y2 = pos_y + hit_y_hi;

  assign hurt_x1 = pos_x + (side ? hurt_x_lo_right : hurt_x_lo_left);
  assign hurt_x2 = pos_x + (side ? hurt_x_hi_right : hurt_x_hi_left);
  assign hurt_y1 = pos_y;
  assign hurt_y2 = pos_y + hurt_y_hi;

  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    state inside {idle, move_forward, move_backward, attack_start, attack_end, attack_pull})
    else $error("player: illegal state %0h.", state);

  a_pos_in_arena: assert property (@(posedge clk) disable iff (rst)
    pos_x >= arena_min && pos_x <= arena_max)
    else $error("player: pos_x %0d outside the arena.", pos_x);

endmodule

/* hdl/hit_detect.sv */
`timescale 1ns/1ps

module hit_detect (
  input  logic                            clk,
  input  logic                            rst,
  input  fight_state_pkg::fighter_state_t attacker_state,
  input  fight_geom_pkg::coord_t          atk_x1,
  input  fight_geom_pkg::coord_t          atk_x2,
  input  fight_geom_pkg::coord_t          atk_y1,
  input  fight_geom_pkg::coord_t          atk_y2,
  input  fight_geom_pkg::coord_t          def_x1,
  input  fight_geom_pkg::coord_t          def_x2,
  input  fight_geom_pkg::coord_t          def_y1,
  input  fight_geom_pkg::coord_t          def_y2,
  output logic                            hit
);
  import fight_state_pkg::*;

  logic overlap;
  logic active;
  logic landed; // this attack has already connected.
  logic fire;

  // boxes touch only when every low edge sits strictly below the other high edge.
  assign overlap = (atk_x1 < def_x2) && (def_x1 < atk_x2) &&
                   (atk_y1 < def_y2) && (def_y1 < atk_y2);
  assign active = (attacker_state == attack_end);
  assign fire = active && overlap && !landed;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hit <= 1'b0;
      landed <= 1'b0;
    end else begin
      hit <= fire;
      if (!active) begin
        landed <= 1'b0;
      end else if (fire) begin
        landed <= 1'b1;
      end
    end
  end

  a_single_pulse: assert property (@(posedge clk) disable iff (rst) hit |=> !hit)
    else $error("hit_detect: hit held for two cycles.");

endmodule

/* hdl/health_tracker.sv */
`timescale 1ns/1ps

module health_tracker (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 hit_on_left,
  input  logic                                 hit_on_right,
  output logic [fight_state_pkg::health_w-1:0] health_left,
  output logic [fight_state_pkg::health_w-1:0] health_right,
  output logic                                 ko
);
  import fight_state_pkg::*;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      health_left <= health_full;
      health_right <= health_full;
      ko <= 1'b0;
    end else begin
      if (hit_on_left && health_left != '0) begin
        health_left <= health_left - 1'b1;
      end
      if (hit_on_right && health_right != '0) begin
        health_right <= health_right - 1'b1;
      end
      // sticky until reset, raised the cycle after a health reaches zero.
      if (health_left == '0 || health_right == '0) begin
        ko <= 1'b1;
      end
    end
  end

  a_health_bound: assert property (@(posedge clk) disable iff (rst)
    health_left <= health_full && health_right <= health_full)
    else $error("health_tracker: health above full, %0h %0h.", health_left, health_right);

endmodule

/* hdl/fight_top.sv */
`timescale 1ns/1ps

module fight_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 left_l,
  input  logic                                 right_l,
  input  logic                                 attack_l,
  input  logic                                 left_r,
  input  logic                                 right_r,
  input  logic                                 attack_r,
  output fight_state_pkg::fighter_state_t      state_l,
  output fight_state_pkg::fighter_state_t      state_r,
  output fight_geom_pkg::coord_t               pos_x_l,
  output fight_geom_pkg::coord_t               pos_x_r,
  output fight_geom_pkg::coord_t               pos_y_l,
  output fight_geom_pkg::coord_t               pos_y_r,
  output logic [fight_state_pkg::health_w-1:0] health_l,
  output logic [fight_state_pkg::health_w-1:0] health_r,
  output logic                                 hit_l,
  output logic                                 hit_r,
  output logic                                 ko
);
  import fight_geom_pkg::*;

  logic   live; // both fighters freeze once the bout is decided.
  coord_t hit_x1_l, hit_x2_l, hit_y1_l, hit_y2_l, hurt_x1_l, hurt_x2_l, hurt_y1_l, hurt_y2_l;
  coord_t hit_x1_r, hit_x2_r, hit_y1_r, hit_y2_r, hurt_x1_r, hurt_x2_r, hurt_y1_r, hurt_y2_r;

  assign live = !ko;

  player #(.side(1'b0)) u_player_l (
    .clk(clk), .rst(rst),
    .left(left_l && live), .right(right_l && live), .attack(attack_l && live),
    .state(state_l), .pos_x(pos_x_l), .pos_y(pos_y_l),
    .hit_x1(hit_x1_l), .hit_x2(hit_x2_l), .hit_y1(hit_y1_l), .hit_y2(hit_y2_l),
    .hurt_x1(hurt_x1_l), .hurt_x2(hurt_x2_l), .hurt_y1(hurt_y1_l), .hurt_y2(hurt_y2_l)
  );

  player #(.side(1'b1)) u_player_r (
    .clk(clk), .rst(rst),
    .left(left_r && live), .right(right_r && live), .attack(attack_r && live),
    .state(state_r), .pos_x(pos_x_r), .pos_y(pos_y_r),
    .hit_x1(hit_x1_r), .hit_x2(hit_x2_r), .hit_y1(hit_y1_r), .hit_y2(hit_y2_r),
    .hurt_x1(hurt_x1_r), .hurt_x2(hurt_x2_r), .hurt_y1(hurt_y1_r), .hurt_y2(hurt_y2_r)
  );

  hit_detect u_hit_l (
    .clk(clk), .rst(rst), .attacker_state(state_l),
    .atk_x1(hit_x1_l), .atk_x2(hit_x2_l), .atk_y1(hit_y1_l), .atk_y2(hit_y2_l),
    .def_x1(hurt_x1_r), .def_x2(hurt_x2_r), .def_y1(hurt_y1_r), .def_y2(hurt_y2_r),
    .hit(hit_l)
  );

  hit_detect u_hit_r (
    .clk(clk), .rst(rst), .attacker_state(state_r),
    .atk_x1(hit_x1_r), .atk_x2(hit_x2_r), .atk_y1(hit_y1_r), .atk_y2(hit_y2_r),
    .def_x1(hurt_x1_l), .def_x2(hurt_x2_l), .def_y1(hurt_y1_l), .def_y2(hurt_y2_l),
    .hit(hit_r)
  );

  health_tracker u_health (
    .clk(clk), .rst(rst),
    .hit_on_left(hit_r), .hit_on_right(hit_l), // a hit landed by one side hurts the other.
    .health_left(health_l), .health_right(health_r), .ko(ko)
  );

endmodule

/* tests/fight_checker.sv */
`timescale 1ns/1ps

module fight_checker (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 left_l,
  input  logic                                 right_l,
  input  logic                                 attack_l,
  input  logic                                 left_r,
  input  logic                                 right_r,
  input  logic                                 attack_r,
  input  fight_state_pkg::fighter_state_t      state_l,
  input  fight_state_pkg::fighter_state_t      state_r,
  input  fight_geom_pkg::coord_t               pos_x_l,
  input  fight_geom_pkg::coord_t               pos_x_r,
  input  fight_geom_pkg::coord_t               pos_y_l,
  input  fight_geom_pkg::coord_t               pos_y_r,
  input  logic [fight_state_pkg::health_w-1:0] health_l,
  input  logic [fight_state_pkg::health_w-1:0] health_r,
  input  logic                                 hit_l,
  input  logic                                 hit_r,
  input  logic                                 ko,
  output int                                   errors
);
  import fight_geom_pkg::*;
  import fight_state_pkg::*;

  fighter_state_t m_state [2];
  int m_cnt [2]; // cycles spent in the current state.
  int m_x [2];
  int m_health [2];
  logic m_landed [2];
  logic m_hit [2]; // index 0 is a hit landed by the left fighter.
  logic m_ko;
  logic [2:0] ctl [2];
  int err_count = 0;

  assign ctl[0] = {left_l, right_l, attack_l};
  assign ctl[1] = {left_r, right_r, attack_r};
  assign errors = err_count;

  function automatic fighter_state_t ref_state(fighter_state_t s, int n, logic [2:0] c, bit side);
    logic toward;
    logic away;
    toward = side ? c[2] : c[1];
    away = side ? c[1] : c[2];
    case (s)
      attack_start: return (n == startup_len - 1) ? attack_end : attack_start;
      attack_end: return (n == active_len - 1) ? attack_pull : attack_end;
      attack_pull: return (n == recovery_len - 1) ? idle : attack_pull;
      default: begin
        if (c[0]) return attack_start;
        if (c[2] && c[1]) return move_backward;
        if (toward) return move_forward;
        if (away) return move_backward;
        return idle;
      end
    endcase
  endfunction

  function automatic int ref_pos(fighter_state_t s, int x, bit side);
    int nx;
    nx = x;
    if ((s == move_forward) != side && (s == move_forward || s == move_backward)) begin
      nx = x + int'(move_speed); // toward higher x.
    end else if (s == move_forward || s == move_backward) begin
      nx = x - int'(move_speed);
    end
    if (nx < int'(arena_min) || nx > int'(arena_max)) return int'(arena_home);
    return nx;
  endfunction

  function automatic bit ref_overlap(int ax, int dx, bit dside);
    int hx1;
    int hx2;
    int ux1;
    int ux2;
    hx1 = ax + int'(hit_x_lo);
    hx2 = ax + int'(hit_x_hi);
    ux1 = dx + int'(dside ? hurt_x_lo_right : hurt_x_lo_left);
    ux2 = dx + int'(dside ? hurt_x_hi_right : hurt_x_hi_left);
    // both fighters stand on the same y, so only the offsets matter there.
    return hx1 < ux2 && ux1 < hx2 && int'(hit_y_lo) < int'(hurt_y_hi) && 0 < int'(hit_y_hi);
  endfunction

  always @(posedge clk or posedge rst) begin : model
    fighter_state_t nxt;
    logic fire;
    if (rst) begin
      m_state <= '{idle, idle};
      m_cnt <= '{0, 0};
      m_x <= '{int'(start_x_left), int'(start_x_right)};
      m_health <= '{int'(health_full), int'(health_full)};
      m_landed <= '{1'b0, 1'b0};
      m_hit <= '{1'b0, 1'b0};
      m_ko <= 1'b0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        nxt = ref_state(m_state[i], m_cnt[i], ctl[i] & {3{!m_ko}}, i[0]);
        fire = m_state[i] == attack_end && !m_landed[i] &&
               ref_overlap(m_x[i], m_x[1-i], i == 0);
        m_cnt[i] <= (nxt == m_state[i]) ? m_cnt[i] + 1 : 0;
        m_state[i] <= nxt;
        m_x[i] <= ref_pos(m_state[i], m_x[i], i[0]);
        m_landed[i] <= (m_state[i] == attack_end) && (m_landed[i] || fire);
        m_hit[i] <= fire;
        if (m_hit[1-i] && m_health[i] != 0) begin
          m_health[i] <= m_health[i] - 1;
        end
      end
      if (m_health[0] == 0 || m_health[1] == 0) begin
        m_ko <= 1'b1;
      end
    end
  end

  task automatic compare(string name, int exp, int act);
    if (exp != act) begin
      err_count++;
      $display("MISMATCH %s expected %0h actual %0h at %0t", name, exp, act, $time);
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      compare("state_l", m_state[0], state_l);
      compare("state_r", m_state[1], state_r);
      compare("pos_x_l", m_x[0], int'(pos_x_l));
      compare("pos_x_r", m_x[1], int'(pos_x_r));
      compare("pos_y_l", int'(start_y), int'(pos_y_l));
      compare("pos_y_r", int'(start_y), int'(pos_y_r));
      compare("health_l", m_health[0], int'(health_l));
      compare("health_r", m_health[1], int'(health_r));
      compare("hit_l", m_hit[0], hit_l);
      compare("hit_r", m_hit[1], hit_r);
      compare("ko", m_ko, ko);
    end
  end

endmodule

/* tests/tb_fight_top.sv */
`timescale 1ns/1ps

module tb_fight_top;
  import fight_geom_pkg::*;
  import fight_state_pkg::*;

  logic clk, rst;
  logic left_l, right_l, attack_l, left_r, right_r, attack_r;
  fighter_state_t state_l, state_r;
  coord_t pos_x_l, pos_x_r, pos_y_l, pos_y_r;
  logic [health_w-1:0] health_l, health_r;
  logic hit_l, hit_r, ko;
  int mismatches;
  int local_errs = 0;
  int passed = 0;
  int failed = 0;
  int errs_before = 0;
  int hits_seen = 0; // hit pulses landed by the left fighter.
  int hits_seen_r = 0;

  fight_top u_fight_top (.*);
  fight_checker u_checker (.*, .errors(mismatches));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    if (hit_l) hits_seen++;
    if (hit_r) hits_seen_r++;
  end

  task automatic step(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drive(logic [2:0] ctl_l, logic [2:0] ctl_r);
    {left_l, right_l, attack_l} = ctl_l;
    {left_r, right_r, attack_r} = ctl_r;
  endtask

  task automatic expect_val(string name, int exp, int act);
    if (exp != act) begin
      local_errs++;
      $display("MISMATCH %s expected %0h actual %0h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic report_error(string what);
    local_errs++;
    $display("ERROR: %s at %0t", what, $time);
  endtask

  task automatic start_test();
    errs_before = local_errs + mismatches;
  endtask

  task automatic finish_test(string name);
    if (local_errs + mismatches == errs_before) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: failed", name);
    end
  endtask

  task automatic wait_state(bit right_side, fighter_state_t s, int limit);
    int n;
    n = 0;
    while ((right_side ? state_r : state_l) != s && n < limit) begin
      step(1);
      n++;
    end
    if ((right_side ? state_r : state_l) != s) begin
      if (right_side) report_error($sformatf("timeout waiting for right state %0h", s));
      else report_error($sformatf("timeout waiting for left state %0h", s));
    end
  endtask

  task automatic phase_len(fighter_state_t s, int exp);
    int n;
    n = 0;
    while (state_l == s && n < 40) begin
      step(1);
      n++;
    end
    expect_val("state_l cycles", exp, n);
  endtask

  task automatic check_move(bit right_side, logic [1:0] dir, fighter_state_t exp_s, int delta);
    int x0;
    x0 = int'(right_side ? pos_x_r : pos_x_l);
    if (right_side) drive(3'b000, {dir, 1'b0});
    else drive({dir, 1'b0}, 3'b000);
    step(1);
    expect_val(right_side ? "state_r" : "state_l", exp_s, right_side ? state_r : state_l);
    step(1);
    expect_val(right_side ? "pos_x_r" : "pos_x_l", x0 + delta,
               int'(right_side ? pos_x_r : pos_x_l));
    drive(3'b000, 3'b000);
    step(2);
  endtask

  task automatic walk_to_edge(bit right_side);
    int prev;
    int n;
    bit seen;
    n = 0;
    seen = 0;
    if (right_side) drive(3'b000, 3'b010);
    else drive(3'b100, 3'b000);
    while (!seen && n < 80) begin
      prev = int'(right_side ? pos_x_r : pos_x_l);
      step(1);
      n++;
      seen = int'(right_side ? pos_x_r : pos_x_l) == int'(arena_home) &&
             (right_side ? prev + 10 > int'(arena_max) : prev - 10 < int'(arena_min));
    end
    drive(3'b000, 3'b000);
    step(2);
    if (!seen) report_error("fighter was not put back home at the arena edge");
  endtask

  task automatic attack_once(bit right_side);
    if (right_side) drive(3'b000, 3'b001);
    else drive(3'b001, 3'b000);
    wait_state(right_side, attack_start, 3);
    drive(3'b000, 3'b000);
    wait_state(right_side, idle, 40);
    step(1);
  endtask

  initial begin
    int hits_before;
    int h0;
    int x_l;
    int x_r;
    int n;
    bit frozen;
    void'($urandom(32'h5f60_5587));
    rst = 1'b1;
    drive(3'b000, 3'b000);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    start_test();
    expect_val("state_l", idle, state_l);
    expect_val("state_r", idle, state_r);
    expect_val("pos_x_l", 210, int'(pos_x_l));
    expect_val("pos_x_r", 420, int'(pos_x_r));
    expect_val("pos_y_l", 140, int'(pos_y_l));
    expect_val("pos_y_r", 140, int'(pos_y_r));
    expect_val("health_l", 5, int'(health_l));
    expect_val("health_r", 5, int'(health_r));
    expect_val("hit_l", 0, hit_l);
    expect_val("hit_r", 0, hit_r);
    expect_val("ko", 0, ko);
    finish_test("reset");

    start_test();
    check_move(1'b0, 2'b01, move_forward, 10);
    check_move(1'b0, 2'b10, move_backward, -10);
    check_move(1'b0, 2'b11, move_backward, -10);
    check_move(1'b1, 2'b10, move_forward, -10);
    check_move(1'b1, 2'b01, move_backward, 10);
    check_move(1'b1, 2'b11, move_backward, 10);
    finish_test("movement");

    // fighters are still far apart here, so this attack must miss.
    start_test();
    hits_before = hits_seen;
    drive(3'b011, 3'b000);
    wait_state(1'b0, attack_start, 3);
    drive(3'b010, 3'b000);
    phase_len(attack_start, startup_len);
    phase_len(attack_end, active_len);
    phase_len(attack_pull, recovery_len);
    expect_val("state_l", idle, state_l);
    expect_val("hit_l pulses", 0, hits_seen - hits_before);
    drive(3'b000, 3'b000);
    step(2);
    finish_test("attack timing");

    start_test();
    walk_to_edge(1'b0);
    walk_to_edge(1'b1);
    finish_test("arena edges");

    start_test();
    hits_before = hits_seen;
    h0 = int'(health_r);
    attack_once(1'b0);
    expect_val("hit_l pulses", 1, hits_seen - hits_before);
    expect_val("health_r", h0 - 1, int'(health_r));
    hits_before = hits_seen_r;
    h0 = int'(health_l);
    attack_once(1'b1);
    expect_val("hit_r pulses", 1, hits_seen_r - hits_before);
    expect_val("health_l", h0 - 1, int'(health_l));
    finish_test("hit in range");

    start_test();
    n = 0;
    while (!ko && n < 8) begin
      attack_once(1'b0);
      n++;
    end
    if (!ko) report_error("no knockout after repeated landed hits");
    expect_val("health_r", 0, int'(health_r));
    x_l = int'(pos_x_l);
    x_r = int'(pos_x_r);
    frozen = 1'b1;
    repeat (30) begin
      drive(3'($urandom), 3'($urandom));
      step(1);
      if (state_l != idle || state_r != idle || int'(pos_x_l) != x_l || int'(pos_x_r) != x_r)
        frozen = 1'b0;
    end
    if (!frozen) report_error("a fighter moved after the knockout");
    finish_test("knockout");

    start_test();
    rst = 1'b1;
    step(4);
    rst = 1'b0;
    repeat (400) begin
      drive(3'($urandom), 3'($urandom));
      step(1);
    end
    drive(3'b000, 3'b000);
    step(2);
    finish_test("random play");

    $display("tests passed %0d, failed %0d, mismatches %0d", passed, failed, mismatches);
    if (failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
hdl/fight_geom_pkg.sv
hdl/fight_state_pkg.sv
hdl/phase_counter.sv
hdl/player.sv
hdl/hit_detect.sv
hdl/health_tracker.sv
hdl/fight_top.sv
tests/fight_checker.sv
tests/tb_fight_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_fight_top -o sim_fight
./obj_dir/sim_fight > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
